//--- common/fletcherPkg.sv
`default_nettype none

package fletcherPkg;

    // ------------------------------
    // Widths
    // ------------------------------
    localparam int ByteWidth = 8;
    localparam int WordWidth = 16;
    localparam int SumWidth  = 2 * WordWidth;

    // Each running sum is reduced modulo 2^16 - 1
    localparam logic [WordWidth-1:0] SumModulus = {WordWidth{1'b1}};

    // ------------------------------
    // Stream beats
    // ------------------------------

    // One input byte. Expected is only meaningful with last
    typedef struct packed {
        logic [ByteWidth-1:0] data;
        logic                 last;
        logic [SumWidth-1:0]  expected;
    } byteBeat_t;

    // One assembled word, first byte in the high half
    typedef struct packed {
        logic [WordWidth-1:0] word;
        logic                 last;
        logic [SumWidth-1:0]  expected;
    } wordBeat_t;

    // Folded checksum of a record, B high and A low
    typedef struct packed {
        logic [SumWidth-1:0] checksum;
        logic [SumWidth-1:0] expected;
    } sumResult_t;

    // Reported record
    typedef struct packed {
        logic [SumWidth-1:0] checksum;
        logic                match;
    } checkResult_t;

endpackage

`default_nettype wire

//--- hdl/byteAssembler.sv
`timescale 1ns/1ps
`default_nettype none

module byteAssembler (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  byteValid,
    input  fletcherPkg::byteBeat_t byteIn,
    output logic                  wordValid,
    output fletcherPkg::wordBeat_t word
);

    logic                                halfFull;  // High byte of a pair is waiting
    logic [fletcherPkg::ByteWidth-1:0]   highByte;

    // ------------------------------
    // Pairing control
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            halfFull  <= 1'b0;
            wordValid <= 1'b0;
        end else begin
            wordValid <= 1'b0;
            if (byteValid) begin
                if (halfFull || byteIn.last) begin
                    wordValid <= 1'b1;  // Pair complete or record closed
                    halfFull  <= 1'b0;  // Next record starts aligned
                end else begin
                    halfFull  <= 1'b1;
                end
            end
        end
    end

    // ------------------------------
    // Payload
    // ------------------------------
    always_ff @(posedge clk) begin
        if (byteValid) begin
            if (halfFull) begin
                word.word <= {highByte, byteIn.data};
            end else begin
                // Odd last byte, low half padded with zero
                word.word <= {byteIn.data, {fletcherPkg::ByteWidth{1'b0}}};
            end
            word.last     <= byteIn.last;
            word.expected <= byteIn.expected;

            if (!halfFull) begin
                highByte <= byteIn.data;  // Held until the low byte shows up
            end
        end
    end

endmodule

`default_nettype wire

//--- fletcher/fletcherChecksum.sv
`timescale 1ns/1ps
`default_nettype none

module fletcherChecksum (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    wordValid,
    input  fletcherPkg::wordBeat_t  word,
    output logic                    sumValid,
    output fletcherPkg::sumResult_t sum
);

    // Add two reduced values and bring the result back into 0..65534
    function automatic logic [fletcherPkg::WordWidth-1:0] addReduce(
        input logic [fletcherPkg::WordWidth-1:0] a,
        input logic [fletcherPkg::WordWidth-1:0] b
    );
        logic [fletcherPkg::WordWidth:0] total;
        total = {1'b0, a} + {1'b0, b};
        if (total >= {1'b0, fletcherPkg::SumModulus}) begin
            total = total - {1'b0, fletcherPkg::SumModulus};
        end
        return total[fletcherPkg::WordWidth-1:0];
    endfunction

    logic [fletcherPkg::WordWidth-1:0] sumA;
    logic [fletcherPkg::WordWidth-1:0] sumB;
    logic [fletcherPkg::WordWidth-1:0] nextA;
    logic [fletcherPkg::WordWidth-1:0] nextB;

    logic                    finalValid;
    fletcherPkg::sumResult_t finalSum;  // First copy of a closed record

    // ------------------------------
    // Running sums
    // ------------------------------
    always_comb begin
        nextA = addReduce(sumA, word.word);
        nextB = addReduce(sumB, nextA);  // B takes the updated A
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sumA <= '0;
            sumB <= '0;
        end else if (wordValid) begin
            if (word.last) begin
                sumA <= '0;  // Ready for the next record right away
                sumB <= '0;
            end else begin
                sumA <= nextA;
                sumB <= nextB;
            end
        end
    end

    // ------------------------------
    // Fold and output
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            finalValid <= 1'b0;
            sumValid   <= 1'b0;
        end else begin
            finalValid <= wordValid && word.last;
            sumValid   <= finalValid;
        end
    end

    always_ff @(posedge clk) begin
        if (wordValid && word.last) begin
            finalSum.checksum <= {nextB, nextA};
            finalSum.expected <= word.expected;
        end
        if (finalValid) begin
            // Separate copy so a short next record cannot overwrite it
            sum <= finalSum;
        end
    end

endmodule

`default_nettype wire

//--- hdl/recordChecker.sv
`timescale 1ns/1ps
`default_nettype none

module recordChecker (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      sumValid,
    input  fletcherPkg::sumResult_t   sum,
    output logic                      done,
    output fletcherPkg::checkResult_t result
);

    logic checksumMatch;

    // ------------------------------
    // Compare
    // ------------------------------
    always_comb begin
        checksumMatch = (sum.checksum == sum.expected);
    end

    // ------------------------------
    // Report
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            done   <= 1'b0;
            result <= '0;
        end else begin
            done <= sumValid;  // One pulse per record
            if (sumValid) begin
                result.checksum <= sum.checksum;
                result.match    <= checksumMatch;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/checksumTop.sv
`timescale 1ns/1ps
`default_nettype none

module checksumTop (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      byteValid,
    input  fletcherPkg::byteBeat_t    byteIn,
    output logic                      done,
    output fletcherPkg::checkResult_t result
);

    logic                    wordValid;
    fletcherPkg::wordBeat_t  word;
    logic                    sumValid;
    fletcherPkg::sumResult_t sum;

    // ------------------------------
    // Bytes to words
    // ------------------------------
    byteAssembler byteAssembler_i (
        .clk       (clk),
        .rst       (rst),
        .byteValid (byteValid),
        .byteIn    (byteIn),
        .wordValid (wordValid),
        .word      (word)
    );

    // ------------------------------
    // Fletcher-32 sums
    // ------------------------------
    fletcherChecksum fletcherChecksum_i (
        .clk       (clk),
        .rst       (rst),
        .wordValid (wordValid),
        .word      (word),
        .sumValid  (sumValid),
        .sum       (sum)
    );

    // ------------------------------
    // Compare and report
    // ------------------------------
    recordChecker recordChecker_i (
        .clk      (clk),
        .rst      (rst),
        .sumValid (sumValid),
        .sum      (sum),
        .done     (done),
        .result   (result)
    );

endmodule

`default_nettype wire

//--- tests/checksumModel.svh
`ifndef CHECKSUM_MODEL_SVH
`define CHECKSUM_MODEL_SVH

// ------------------------------
// Fletcher-32 reference
// ------------------------------

// Bytes pair into 16-bit words, first byte high
// An odd final byte gets a zero low byte
// Sum A takes each word, sum B takes each new A, both mod 65535
// Result is B in the high half and A in the low half
function automatic logic [31:0] fletcher32Model(input logic [7:0] recordBytes[$]);
    int unsigned sumA;
    int unsigned sumB;
    int unsigned pairWord;
    int          i;

    sumA = 0;
    sumB = 0;
    for (i = 0; i < recordBytes.size(); i += 2) begin
        pairWord = {16'd0, recordBytes[i], 8'd0};
        if (i + 1 < recordBytes.size()) begin
            pairWord = pairWord | {24'd0, recordBytes[i + 1]};
        end
        sumA = (sumA + pairWord) % 65535;
        sumB = (sumB + sumA) % 65535;  // B takes the updated A
    end
    return {sumB[15:0], sumA[15:0]};
endfunction

`endif

//--- tests/checksumTb.sv
`timescale 1ns/1ps
`default_nettype none

module checksumTb;

    localparam int ClockPeriod   = 100;
    localparam int ResetCycles   = 10;
    localparam int DriveDelay    = 1;
    localparam int DoneEdges     = 3;    // Done loads on the 3rd edge, seen by the 4th
    localparam int TimeoutMargin = 100;

    logic                      clk;
    logic                      rst;
    logic                      byteValid;
    fletcherPkg::byteBeat_t    byteIn;
    logic                      done;
    fletcherPkg::checkResult_t result;

    integer seed           = 32'h2628_6c19;
    int     edgeCount      = 0;
    int     cycleBudget    = ResetCycles;  // Grows with every byte and idle cycle driven
    int     errorCount     = 0;
    int     protocolErrors = 0;

    // Records waiting for their done, oldest first
    logic [31:0] expChecksum[$];
    logic        expMatch[$];
    int          expEdge[$];
    string       expName[$];

    `include "checksumModel.svh"

    checksumTop checksumTop_i (
        .clk       (clk),
        .rst       (rst),
        .byteValid (byteValid),
        .byteIn    (byteIn),
        .done      (done),
        .result    (result)
    );

    initial begin
        clk = 1'b0;
        forever #(ClockPeriod / 2) clk = ~clk;
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    function automatic int randRange(input int lo, input int hi);
        int span;
        span = hi - lo + 1;
        return lo + ($unsigned($random(seed)) % span);
    endfunction

    task automatic checkValue(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic driveByte(input logic [7:0] data, input logic last,
                             input logic [31:0] expected);
        cycleBudget++;
        @(posedge clk);
        #DriveDelay;
        byteValid       = 1'b1;
        byteIn.data     = data;
        byteIn.last     = last;
        byteIn.expected = expected;
    endtask

    task automatic idleCycle();
        cycleBudget++;
        @(posedge clk);
        #DriveDelay;
        byteValid = 1'b0;
        byteIn    = '0;
    endtask

    task automatic dropFront();
        void'(expChecksum.pop_front());
        void'(expMatch.pop_front());
        void'(expEdge.pop_front());
        void'(expName.pop_front());
    endtask

    task automatic sendRecord(input string name, input int len, input int maxGap,
                              input bit fillOnes, input bit corrupt);
        logic [7:0]  recordBytes[$];
        logic [31:0] checksum;
        logic [31:0] expectedValue;
        int          i;
        for (i = 0; i < len; i++) begin
            recordBytes.push_back(fillOnes ? 8'hFF : 8'($random(seed)));
        end
        checksum      = fletcher32Model(recordBytes);
        expectedValue = checksum;
        if (corrupt) begin
            expectedValue = checksum ^ (32'd1 << randRange(0, 31));  // One bit off
        end
        for (i = 0; i < len; i++) begin
            if (i == len - 1) begin
                driveByte(recordBytes[i], 1'b1, expectedValue);
                expChecksum.push_back(checksum);
                expMatch.push_back(checksum == expectedValue);
                expEdge.push_back(edgeCount + 1 + DoneEdges);
                expName.push_back(name);
            end else begin
                driveByte(recordBytes[i], 1'b0, $random(seed));  // Expected ignored here
                repeat (randRange(0, maxGap)) idleCycle();
            end
        end
    endtask

    // ------------------------------
    // Cycle count and timeout
    // ------------------------------
    always @(posedge clk) begin
        edgeCount++;
        if (edgeCount > cycleBudget + TimeoutMargin) begin
            $display("Timeout at cycle %0d, %0d records never reported",
                     edgeCount, expChecksum.size());
            $display("Errors: %0d value, %0d protocol", errorCount, protocolErrors);
            $display("TEST FAIL");
            $finish;
        end
    end

    // ------------------------------
    // Result monitor
    // ------------------------------
    always @(negedge clk) begin
        if (!rst) begin
            if (done) begin
                if (expChecksum.size() == 0) begin
                    $display("Done pulse at cycle %0d with no record pending", edgeCount);
                    protocolErrors++;
                end else begin
                    checkValue({expName[0], " latency"}, expEdge[0], edgeCount);
                    checkValue({expName[0], " checksum"}, expChecksum[0], result.checksum);
                    checkValue({expName[0], " match"}, expMatch[0], result.match);
                    checkValue({expName[0], " sumA range"}, 1,
                               result.checksum[15:0] != 16'hFFFF);
                    checkValue({expName[0], " sumB range"}, 1,
                               result.checksum[31:16] != 16'hFFFF);
                    dropFront();
                end
            end else if (expEdge.size() != 0 && edgeCount > expEdge[0]) begin
                $display("No done for a %s record due at cycle %0d", expName[0], expEdge[0]);
                protocolErrors++;
                dropFront();
            end
        end
    end

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        rst       = 1'b1;
        byteValid = 1'b0;
        byteIn    = '0;
        repeat (ResetCycles) @(posedge clk);
        #DriveDelay;
        rst = 1'b0;

        repeat (20) begin  // Quiet after reset
            idleCycle();
            @(negedge clk);
            checkValue("reset done", 0, done);
            checkValue("reset result", 0, result);
        end

        repeat (20) begin
            sendRecord("even", 2 * randRange(1, 20), 0, 1'b0, 1'b0);
            repeat (randRange(0, 3)) idleCycle();
        end

        sendRecord("odd", 1, 0, 1'b0, 1'b0);
        repeat (15) begin
            sendRecord("odd", 2 * randRange(0, 19) + 1, 0, 1'b0, 1'b0);
            repeat (randRange(0, 3)) idleCycle();
        end

        repeat (10) begin
            sendRecord("corrupt", randRange(1, 40), 0, 1'b0, 1'b1);
            repeat (randRange(0, 3)) idleCycle();
        end

        repeat (10) begin  // Short records stack up in the pipeline
            sendRecord("backToBack", randRange(1, 4), 0, 1'b0, 1'b0);
        end
        repeat (10) begin
            sendRecord("gapped", randRange(1, 40), 3, 1'b0, randRange(0, 1) == 1);
        end

        sendRecord("allOnes", 64, 0, 1'b1, 1'b0);
        sendRecord("allOnes", 257, 0, 1'b1, 1'b0);
        sendRecord("allOnes", 513, 0, 1'b1, 1'b0);

        idleCycle();
        while (expChecksum.size() != 0) @(posedge clk);
        repeat (8) @(posedge clk);  // Catch a stray done

        $display("Errors: %0d value, %0d protocol", errorCount, protocolErrors);
        if (errorCount == 0 && protocolErrors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+tests
common/fletcherPkg.sv
hdl/byteAssembler.sv
fletcher/fletcherChecksum.sv
hdl/recordChecker.sv
hdl/checksumTop.sv
tests/checksumTb.sv

//--- Bender.yml
package:
  name: fletcher_checker

sources:
  # Shared package first
  - common/fletcherPkg.sv
  # Design
  - hdl/byteAssembler.sv
  - fletcher/fletcherChecksum.sv
  - hdl/recordChecker.sv
  - hdl/checksumTop.sv
  # Testbench
  - target: test
    include_dirs:
      - tests
    files:
      - tests/checksumTb.sv
